//--- dispatch_front.f
+incdir+src
src/isa_pkg.sv
src/wb_pkg.sv
src/iq_if.sv
src/wb_fetch.sv
src/instr_queue.sv
src/issue_stage.sv
src/dispatch_front.sv
tests/dispatch_front_assertions.sv
tests/dispatch_front_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the dispatch front testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --timescale 1ns/100ps \
    -f dispatch_front.f --top-module dispatch_front_tb -o dispatch_front_sim
status=$?
if [ $status -ne 0 ]; then
    echo "build failed with status $status"
    exit $status
fi

./obj_dir/dispatch_front_sim +verilator+error+limit+10
status=$?
if [ $status -ne 0 ]; then
    echo "simulation failed with status $status"
    exit $status
fi
exit 0

//--- tests/dispatch_front_tb.sv
`default_nettype none

`include "dispatch_config.svh"

module dispatch_front_tb;
    timeunit 1ns;
    timeprecision 100ps;
    import isa_pkg::*;

    localparam int NUM_ISSUES  = 400;
    localparam int CYCLE_LIMIT = 8000;  // 400 issues at about 18 cycles each.
    localparam int LONG_START  = 600;
    localparam int LONG_CAP    = 400;  // longest the full burst may run.

    logic                   clk;
    logic                   rst;
    logic                   fetch_en;
    logic                   wb_cyc;
    logic                   wb_stb;
    logic [`XLEN-1:0]       wb_adr;
    logic [`XLEN-1:0]       wb_rdata;
    logic                   wb_ack;
    logic                   rob_full;
    logic                   iq_full;
    logic                   issue_valid;
    opcode_e                issue_op;
    logic [`REG_W-1:0]      issue_rd;
    logic [`REG_W-1:0]      issue_rs1;
    logic [`REG_W-1:0]      issue_rs2;
    logic [`XLEN-1:0]       issue_imm;
    logic [`ROB_TAG_W-1:0]  issue_tag;

    logic [`XLEN-1:0]       mem [512];
    logic [31:0]            bus_seed;
    logic [31:0]            rob_seed;
    logic                   pending;
    logic                   long_on;
    logic                   long_done;
    logic                   bus_wait;
    logic                   stall_hold;
    int                     wait_left;
    int                     rob_left;
    int                     rob_cycles;
    int                     cycles;
    int                     edges;
    int                     accepted;
    logic [8:0]             model_idx;
    opcode_e                exp_op;
    opcode_e                held_op;
    logic [`REG_W-1:0]      exp_rd, exp_rs1, exp_rs2;
    logic [`REG_W-1:0]      held_rd, held_rs1, held_rs2;
    logic [`XLEN-1:0]       exp_imm, held_imm, held_adr;
    logic [`ROB_TAG_W-1:0]  exp_tag, held_tag;

    dispatch_front dut_i (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic abort_run(input string reason);
        $display("Testbench failed");
        $fatal(1, "%s", reason);
    endtask

    task automatic check_op(input opcode_e expected, input opcode_e actual);
        if (actual !== expected) begin
            $display("ERR issue_op expected %h actual %h", expected, actual);
            abort_run("issue_op mismatch");
        end
    endtask

    task automatic check_field(input string name, input logic [`XLEN-1:0] expected,
                               input logic [`XLEN-1:0] actual);
        if (actual !== expected) begin
            $display("ERR %s expected %h actual %h", name, expected, actual);
            abort_run("issue field mismatch");
        end
    endtask

    task automatic expect_low(input string name, input logic value);
        if (value !== 1'b0) begin
            $display("ERR %s expected 0 actual %h", name, value);
            abort_run("output not low around reset");
        end
    endtask

    // about 70% legal, 15% nop, 15% illegal codes.
    task automatic fill_memory();
        logic [31:0] s;
        logic [4:0]  code;
        int          pick;
        s = 32'h2352;
        for (int i = 0; i < 512; i++) begin
            s = lcg_next(s);
            pick = int'(s[31:16]) % 100;
            if (pick < 70) code = 5'(pick % 9);
            else if (pick < 85) code = 5'd31;
            else code = 5'(pick - 76);  // 9 to 23.
            s = lcg_next(s);
            mem[i] = {code, s[31:5]};
        end
    endtask

    // walks memory in address order and skips nop and illegal words.
    task automatic next_expected();
        logic [31:0] w;
        logic        found;
        found = 1'b0;
        while (!found) begin
            w = mem[model_idx];
            model_idx = model_idx + 1'b1;
            found   = 1'b1;
            exp_op  = opcode_e'(w[31:27]);
            exp_rd  = w[26:22];
            exp_rs1 = w[21:17];
            exp_rs2 = w[16:12];
            exp_imm = {{20{w[11]}}, w[11:0]};
            case (exp_op)
                op_add, op_sub, op_and, op_or, op_xor: exp_imm = '0;
                op_addi, op_lw: exp_rs2 = '0;
                op_sw, op_beq: exp_rd = '0;
                default: found = 1'b0;
            endcase
        end
    endtask

    // slave answers after 0 to 3 wait cycles.
    always @(posedge clk) begin
        if (!rst) begin
            wb_ack <= 1'b0;
            pending = 1'b0;
        end else if (wb_ack) begin
            wb_ack <= 1'b0;
        end else if (wb_stb) begin
            if (!pending) begin
                bus_seed  = lcg_next(bus_seed);
                wait_left = int'(bus_seed[31:30]);
                pending   = 1'b1;
            end
            if (wait_left == 0) begin
                wb_ack   <= 1'b1;
                wb_rdata <= mem[wb_adr[10:2]];
                pending = 1'b0;
            end else begin
                wait_left = wait_left - 1;
            end
        end
    end

    always @(posedge clk) begin
        if (!rst) begin
            rob_full <= 1'b0;
            rob_left   = 0;
            rob_cycles = 0;
            long_on    = 1'b0;
            long_done  = 1'b0;
        end else begin
            rob_cycles = rob_cycles + 1;
            if (rob_cycles == LONG_START) begin
                rob_full <= 1'b1;
                long_on = 1'b1;
            end else if (long_on) begin
                if (iq_full) long_done = 1'b1;
                // at least 60 cycles and on until the queue has filled.
                if ((rob_cycles >= LONG_START + 60 && long_done)
                        || rob_cycles >= LONG_START + LONG_CAP) begin
                    rob_full <= 1'b0;
                    long_on = 1'b0;
                end
            end else if (rob_left > 0) begin
                rob_left = rob_left - 1;
            end else begin
                rob_seed = lcg_next(rob_seed);
                rob_full <= (rob_seed[31:30] == 2'b00);
                rob_left = int'(rob_seed[29:27]);
            end
        end
    end

    always @(posedge clk) begin
        edges = edges + 1;
        if (edges >= 2 && edges <= 5) begin
            expect_low("wb_cyc", wb_cyc);
            expect_low("wb_stb", wb_stb);
            expect_low("issue_valid", issue_valid);
            expect_low("iq_full", iq_full);
        end
        if (rst) begin
            if (wb_stb && !wb_cyc) abort_run("wb_stb was high while wb_cyc was low");
            if (bus_wait) begin
                if (!wb_stb) abort_run("wb_stb dropped before wb_ack");
                check_field("wb_adr", held_adr, wb_adr);
            end
            if (stall_hold) begin
                if (!issue_valid) abort_run("issue_valid dropped while rob_full was high");
                check_op(held_op, issue_op);
                check_field("issue_rd", `XLEN'(held_rd), `XLEN'(issue_rd));
                check_field("issue_rs1", `XLEN'(held_rs1), `XLEN'(issue_rs1));
                check_field("issue_rs2", `XLEN'(held_rs2), `XLEN'(issue_rs2));
                check_field("issue_imm", held_imm, issue_imm);
                check_field("issue_tag", `XLEN'(held_tag), `XLEN'(issue_tag));
            end
            if (issue_valid && !rob_full) begin
                next_expected();
                check_op(exp_op, issue_op);
                check_field("issue_rd", `XLEN'(exp_rd), `XLEN'(issue_rd));
                check_field("issue_rs1", `XLEN'(exp_rs1), `XLEN'(issue_rs1));
                check_field("issue_rs2", `XLEN'(exp_rs2), `XLEN'(issue_rs2));
                check_field("issue_imm", exp_imm, issue_imm);
                check_field("issue_tag", `XLEN'(exp_tag), `XLEN'(issue_tag));
                exp_tag  = exp_tag + 1'b1;  // wraps at 16.
                accepted = accepted + 1;
            end
        end
        bus_wait   = rst && wb_stb && !wb_ack;
        stall_hold = rst && issue_valid && rob_full;
        held_adr   = wb_adr;
        held_op    = issue_op;
        held_rd    = issue_rd;
        held_rs1   = issue_rs1;
        held_rs2   = issue_rs2;
        held_imm   = issue_imm;
        held_tag   = issue_tag;
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > CYCLE_LIMIT) abort_run("timeout before all instructions were issued");
    end

    initial begin
        rst        = 1'b0;
        fetch_en   = 1'b0;
        wb_ack     = 1'b0;
        wb_rdata   = '0;
        rob_full   = 1'b0;
        bus_seed   = ~32'h2352;  // streams derived from one seed.
        rob_seed   = 32'h2352 ^ 32'ha5a5_a5a5;
        cycles     = 0;
        edges      = 0;
        accepted   = 0;
        model_idx  = '0;
        exp_tag    = '0;
        bus_wait   = 1'b0;
        stall_hold = 1'b0;
        fill_memory();
        repeat (4) @(posedge clk);
        rst      <= 1'b1;
        fetch_en <= 1'b1;
        wait (accepted == NUM_ISSUES);
        if (!long_done) begin
            abort_run("iq_full never rose during the long rob_full burst");
        end else begin
            $display("Testbench passed");
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- tests/dispatch_front_assertions.sv
`default_nettype none

`include "dispatch_config.svh"

module dispatch_front_assertions (
    input logic                   clk,
    input logic                   rst,
    input logic                   wb_cyc,
    input logic                   wb_stb,
    input logic                   wb_ack,
    input logic [`XLEN-1:0]       wb_adr,
    input logic                   rob_full,
    input logic                   issue_valid,
    input isa_pkg::opcode_e       issue_op,
    input logic [`REG_W-1:0]      issue_rd,
    input logic [`REG_W-1:0]      issue_rs1,
    input logic [`REG_W-1:0]      issue_rs2,
    input logic [`XLEN-1:0]       issue_imm,
    input logic [`ROB_TAG_W-1:0]  issue_tag
);
    timeunit 1ns;
    timeprecision 100ps;

    stb_in_cycle: assert property (@(posedge clk) disable iff (!rst) wb_stb |-> wb_cyc)
        else $error("wb_stb high outside a bus cycle");

    // address held until the slave answers.
    adr_held: assert property (@(posedge clk) disable iff (!rst)
        wb_stb && !wb_ack |=> $stable(wb_adr))
        else $error("wb_adr changed before wb_ack");

    issue_held: assert property (@(posedge clk) disable iff (!rst)
        issue_valid && rob_full |=> issue_valid
            && $stable({issue_op, issue_rd, issue_rs1, issue_rs2, issue_imm, issue_tag}))
        else $error("issue outputs changed while rob_full was high");

endmodule

bind dispatch_front dispatch_front_assertions assert_i (.*);

`default_nettype wire

//--- src/dispatch_front.sv
`default_nettype none

`include "dispatch_config.svh"

module dispatch_front (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   fetch_en,
    output logic                   wb_cyc,
    output logic                   wb_stb,
    output logic [`XLEN-1:0]       wb_adr,
    input  logic [`XLEN-1:0]       wb_rdata,
    input  logic                   wb_ack,
    input  logic                   rob_full,
    output logic                   iq_full,
    output logic                   issue_valid,
    output isa_pkg::opcode_e       issue_op,
    output logic [`REG_W-1:0]      issue_rd,
    output logic [`REG_W-1:0]      issue_rs1,
    output logic [`REG_W-1:0]      issue_rs2,
    output logic [`XLEN-1:0]       issue_imm,
    output logic [`ROB_TAG_W-1:0]  issue_tag
);

    iq_if decode_ch ();
    iq_if head_ch ();

    wb_fetch fetch_i (
        .clk      (clk),
        .rst      (rst),
        .fetch_en (fetch_en),
        .wb_rdata (wb_rdata),
        .wb_ack   (wb_ack),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_adr   (wb_adr),
        .dec      (decode_ch.src)
    );

    instr_queue queue_i (
        .clk     (clk),
        .rst     (rst),
        .iq_full (iq_full),
        .in_ch   (decode_ch.dst),
        .out_ch  (head_ch.src)
    );

    issue_stage issue_i (
        .clk         (clk),
        .rst         (rst),
        .rob_full    (rob_full),
        .issue_valid (issue_valid),
        .issue_op    (issue_op),
        .issue_rd    (issue_rd),
        .issue_rs1   (issue_rs1),
        .issue_rs2   (issue_rs2),
        .issue_imm   (issue_imm),
        .issue_tag   (issue_tag),
        .in_ch       (head_ch.dst)
    );

endmodule

`default_nettype wire

//--- src/issue_stage.sv
`default_nettype none

`include "dispatch_config.svh"

module issue_stage (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   rob_full,
    output logic                   issue_valid,
    output isa_pkg::opcode_e       issue_op,
    output logic [`REG_W-1:0]      issue_rd,
    output logic [`REG_W-1:0]      issue_rs1,
    output logic [`REG_W-1:0]      issue_rs2,
    output logic [`XLEN-1:0]       issue_imm,
    output logic [`ROB_TAG_W-1:0]  issue_tag,
    iq_if.dst                      in_ch
);

    logic [`ROB_TAG_W-1:0] tag_cnt;
    logic                  load;

    // stall while an issue waits on a full reorder buffer.
    assign in_ch.ready = !issue_valid || !rob_full;
    assign load        = in_ch.valid && in_ch.ready;

    always_ff @(posedge clk) begin
        if (!rst) begin
            issue_valid <= 1'b0;
            tag_cnt     <= '0;
        end else if (load) begin
            issue_valid <= 1'b1;
            tag_cnt     <= tag_cnt + 1'b1;  // wraps at 16.
        end else if (!rob_full) begin
            issue_valid <= 1'b0;  // accepted, nothing new.
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            issue_op  <= in_ch.op;
            issue_rd  <= in_ch.rd;
            issue_rs1 <= in_ch.rs1;
            issue_rs2 <= in_ch.rs2;
            issue_imm <= in_ch.imm;
            issue_tag <= tag_cnt;
        end
    end

endmodule

`default_nettype wire

//--- src/instr_queue.sv
`default_nettype none

`include "dispatch_config.svh"

module instr_queue (
    input  logic  clk,
    input  logic  rst,
    output logic  iq_full,
    iq_if.dst     in_ch,
    iq_if.src     out_ch
);
    import isa_pkg::*;

    opcode_e              op_mem  [`IQ_DEPTH];
    logic [`REG_W-1:0]    rd_mem  [`IQ_DEPTH];
    logic [`REG_W-1:0]    rs1_mem [`IQ_DEPTH];
    logic [`REG_W-1:0]    rs2_mem [`IQ_DEPTH];
    logic [`XLEN-1:0]     imm_mem [`IQ_DEPTH];

    logic [`IQ_PTR_W-1:0] head;
    logic [`IQ_PTR_W-1:0] tail;
    logic [`IQ_PTR_W:0]   count;  // one extra bit to reach depth.
    logic                 push;
    logic                 pop;

    assign iq_full      = (count == `IQ_DEPTH);
    assign in_ch.ready  = !iq_full;
    assign out_ch.valid = (count != '0);

    assign push = in_ch.valid && in_ch.ready;
    assign pop  = out_ch.valid && out_ch.ready;

    // head entry shown directly.
    assign out_ch.op  = op_mem[head];
    assign out_ch.rd  = rd_mem[head];
    assign out_ch.rs1 = rs1_mem[head];
    assign out_ch.rs2 = rs2_mem[head];
    assign out_ch.imm = imm_mem[head];

    always_ff @(posedge clk) begin
        if (push) begin
            op_mem[tail]  <= in_ch.op;
            rd_mem[tail]  <= in_ch.rd;
            rs1_mem[tail] <= in_ch.rs1;
            rs2_mem[tail] <= in_ch.rs2;
            imm_mem[tail] <= in_ch.imm;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            if (push) tail <= tail + 1'b1;  // wraps at depth.
            if (pop) head <= head + 1'b1;
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- src/wb_fetch.sv
`default_nettype none

`include "dispatch_config.svh"

module wb_fetch (
    input  logic              clk,
    input  logic              rst,
    input  logic              fetch_en,
    input  logic [`XLEN-1:0]  wb_rdata,
    input  logic              wb_ack,
    output logic              wb_cyc,
    output logic              wb_stb,
    output logic [`XLEN-1:0]  wb_adr,
    iq_if.src                 dec
);
    import isa_pkg::*;
    import wb_pkg::*;

    fetch_state_e       state;
    logic [`XLEN-1:0]   pc;
    opcode_e            raw_op;
    logic               keep;
    logic [`REG_W-1:0]  d_rd;
    logic [`REG_W-1:0]  d_rs1;
    logic [`REG_W-1:0]  d_rs2;
    logic [`XLEN-1:0]   d_imm;

    assign wb_cyc    = (state == fs_bus);
    assign wb_stb    = (state == fs_bus);
    assign wb_adr    = pc;
    assign dec.valid = (state == fs_push);

    assign raw_op = opcode_e'(wb_rdata[OPC_LSB +: OPC_W]);

    // field selection by instruction form.
    always_comb begin
        keep  = 1'b1;
        d_rd  = wb_rdata[RD_LSB +: `REG_W];
        d_rs1 = wb_rdata[RS1_LSB +: `REG_W];
        d_rs2 = wb_rdata[RS2_LSB +: `REG_W];
        d_imm = {{(`XLEN-IMM_W){wb_rdata[IMM_W-1]}}, wb_rdata[IMM_W-1:0]};
        case (raw_op)
            op_add, op_sub, op_and, op_or, op_xor: d_imm = '0;
            op_addi, op_lw: d_rs2 = '0;
            op_sw, op_beq: d_rd = '0;
            default: keep = 1'b0;  // nop and illegal words.
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            state <= fs_idle;
            pc    <= '0;
        end else begin
            case (state)
                fs_idle: begin
                    if (fetch_en) state <= fs_bus;
                end
                fs_bus: begin
                    if (wb_ack) begin
                        if (keep) state <= fs_push;
                        else pc <= pc + (`XLEN)'(4);  // skip, next read right away.
                    end
                end
                fs_push: begin
                    if (dec.ready) begin
                        pc    <= pc + (`XLEN)'(4);
                        state <= fs_idle;
                    end
                end
                default: state <= fs_idle;
            endcase
        end
    end

    // decoded fields, captured on the ack cycle.
    always_ff @(posedge clk) begin
        if (state == fs_bus && wb_ack && keep) begin
            dec.op  <= raw_op;
            dec.rd  <= d_rd;
            dec.rs1 <= d_rs1;
            dec.rs2 <= d_rs2;
            dec.imm <= d_imm;
        end
    end

endmodule

`default_nettype wire

//--- src/iq_if.sv
`default_nettype none

`include "dispatch_config.svh"

interface iq_if;
    import isa_pkg::*;

    logic                valid;
    logic                ready;
    opcode_e             op;
    logic [`REG_W-1:0]   rd;
    logic [`REG_W-1:0]   rs1;
    logic [`REG_W-1:0]   rs2;
    logic [`XLEN-1:0]    imm;

    modport src (
        output valid, op, rd, rs1, rs2, imm,
        input  ready
    );

    modport dst (
        input  valid, op, rd, rs1, rs2, imm,
        output ready
    );

endinterface

`default_nettype wire

//--- src/wb_pkg.sv
`default_nettype none

package wb_pkg;

    typedef enum logic [1:0] {
        fs_idle,
        fs_bus,   // cyc and stb held until ack.
        fs_push
    } fetch_state_e;

endpackage

`default_nettype wire

//--- src/isa_pkg.sv
`default_nettype none

package isa_pkg;

    typedef enum logic [4:0] {
        op_add  = 5'd0,
        op_sub  = 5'd1,
        op_and  = 5'd2,
        op_or   = 5'd3,
        op_xor  = 5'd4,
        op_addi = 5'd5,  // immediate forms.
        op_lw   = 5'd6,
        op_sw   = 5'd7,  // store and branch forms.
        op_beq  = 5'd8,
        op_nop  = 5'd31
    } opcode_e;

    // instruction word field positions.
    localparam int OPC_W   = 5;
    localparam int OPC_LSB = 27;
    localparam int RD_LSB  = 22;
    localparam int RS1_LSB = 17;
    localparam int RS2_LSB = 12;
    localparam int IMM_W   = 12;

endpackage

`default_nettype wire

//--- src/dispatch_config.svh
`ifndef DISPATCH_CONFIG_SVH
`define DISPATCH_CONFIG_SVH

// queue geometry.
`define IQ_DEPTH 16
`define IQ_PTR_W 4

// datapath and register file.
`define XLEN 32
`define REG_W 5

// reorder-buffer tag space.
`define ROB_TAG_W 4

`endif
